// ==== hw/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and register file
`define DATA_WIDTH 32
`define NUM_REGS 16
`define REG_IDX_W 4

// Queue and reorder buffer sizing
`define IQ_DEPTH 8
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// Multiplier pipeline stages
`define MUL_LATENCY 3

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none
`include "core_macros.svh"

package core_pkg;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mul
  } opcode_t;

  typedef struct packed {
    opcode_t               opcode;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] ra;
    logic [`REG_IDX_W-1:0] rb;
  } inst_t;

  typedef struct packed {
    inst_t                 inst;
    logic [`ROB_IDX_W-1:0] tag;
  } iq_entry_t;

  typedef struct packed {
    opcode_t                opcode;
    logic [`ROB_IDX_W-1:0]  tag;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
  } exec_req_t;

  typedef struct packed {
    logic [`ROB_IDX_W-1:0]  tag;
    logic [`DATA_WIDTH-1:0] value;
  } exec_result_t;

  typedef struct packed {
    logic [`REG_IDX_W-1:0]  rd;
    logic [`DATA_WIDTH-1:0] value;
  } retire_t;

  // Tag of the asking instruction bounds the search to older slots
  typedef struct packed {
    logic [`REG_IDX_W-1:0] reg_idx;
    logic [`ROB_IDX_W-1:0] tag;
  } operand_query_t;

  typedef struct packed {
    logic                   hit;
    logic                   ready;
    logic [`DATA_WIDTH-1:0] value;
  } operand_reply_t;

endpackage

`default_nettype wire

// ==== hw/alu_unit.sv ====
`default_nettype none

module alu_unit (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       req_valid,
  input  wire core_pkg::exec_req_t  req,
  output logic                      res_valid,
  output core_pkg::exec_result_t    res
);
  import core_pkg::*;

  exec_result_t result;

  always_comb begin
    result.tag = req.tag;
    case (req.opcode)
      op_add:  result.value = req.a + req.b;
      op_sub:  result.value = req.a - req.b;
      op_and:  result.value = req.a & req.b;
      op_or:   result.value = req.a | req.b;
      op_xor:  result.value = req.a ^ req.b;
      default: result.value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset)
      res_valid <= 1'b0;
    else
      res_valid <= req_valid;
  end

  always_ff @(posedge clock) begin
    if (req_valid)
      res <= result;
  end

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
`default_nettype none
`include "core_macros.svh"

module mul_unit (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       req_valid,
  input  wire core_pkg::exec_req_t  req,
  output logic                      res_valid,
  output core_pkg::exec_result_t    res
);
  import core_pkg::*;

  logic [`MUL_LATENCY-1:0] valid_q;
  exec_result_t            stage_q [`MUL_LATENCY];

  always_ff @(posedge clock) begin
    if (reset)
      valid_q <= '0;
    else
      valid_q <= {valid_q[`MUL_LATENCY-2:0], req_valid};
  end

  // Low half of the product enters the first stage, tag rides along
  always_ff @(posedge clock) begin
    stage_q[0].tag   <= req.tag;
    stage_q[0].value <= req.a * req.b;
    for (int i = 1; i < `MUL_LATENCY; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign res_valid = valid_q[`MUL_LATENCY-1];
  assign res       = stage_q[`MUL_LATENCY-1];

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none
`include "core_macros.svh"

module reg_file (
  input  wire                      clock,
  input  wire                      reset,
  input  wire [`REG_IDX_W-1:0]     rd_addr_a,
  input  wire [`REG_IDX_W-1:0]     rd_addr_b,
  output logic [`DATA_WIDTH-1:0]   rd_data_a,
  output logic [`DATA_WIDTH-1:0]   rd_data_b,
  input  wire                      wr_valid,
  input  wire core_pkg::retire_t   wr
);

  logic [`DATA_WIDTH-1:0] regs_q [`NUM_REGS];

  assign rd_data_a = regs_q[rd_addr_a];
  assign rd_data_b = regs_q[rd_addr_b];

  // Architectural state starts at zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_valid) begin
      regs_q[wr.rd] <= wr.value;
    end
  end

endmodule

`default_nettype wire

// ==== hw/inst_queue.sv ====
`default_nettype none
`include "core_macros.svh"

module inst_queue (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       push,
  input  wire core_pkg::iq_entry_t  push_entry,
  input  wire                       pop,
  output logic                      head_valid,
  output core_pkg::iq_entry_t       head,
  output logic [$clog2(`IQ_DEPTH):0] count
);
  import core_pkg::*;

  localparam int PTR_W = $clog2(`IQ_DEPTH);

  iq_entry_t        mem_q [`IQ_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W:0]   count_q;

  assign head_valid = (count_q != '0);
  assign head       = mem_q[head_q];
  assign count      = count_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push)
        tail_q <= tail_q + 1'b1;
      if (pop)
        head_q <= head_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push)
      mem_q[tail_q] <= push_entry;
  end

  no_push_when_full: assert property (
    @(posedge clock) disable iff (reset) push |-> (count_q < `IQ_DEPTH)
  );
  no_pop_when_empty: assert property (
    @(posedge clock) disable iff (reset) pop |-> (count_q != '0)
  );

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`default_nettype none
`include "core_macros.svh"

module reorder_buffer (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           alloc,
  input  wire [`REG_IDX_W-1:0]          alloc_rd,
  output logic [`ROB_IDX_W-1:0]         alloc_tag,
  output logic                          rob_free,
  input  wire core_pkg::operand_query_t query_a,
  input  wire core_pkg::operand_query_t query_b,
  output core_pkg::operand_reply_t      reply_a,
  output core_pkg::operand_reply_t      reply_b,
  input  wire                           alu_res_valid,
  input  wire core_pkg::exec_result_t   alu_res,
  input  wire                           mul_res_valid,
  input  wire core_pkg::exec_result_t   mul_res,
  output logic                          retire_valid,
  output core_pkg::retire_t             retire
);
  import core_pkg::*;

  localparam int IDX_W = `ROB_IDX_W;

  logic [`ROB_DEPTH-1:0]  busy_q;
  logic [`ROB_DEPTH-1:0]  done_q;
  logic [`REG_IDX_W-1:0]  rd_q [`ROB_DEPTH];
  logic [`DATA_WIDTH-1:0] value_q [`ROB_DEPTH];
  logic [IDX_W-1:0]       head_q;
  logic [IDX_W-1:0]       tail_q;
  logic                   head_retire;

  assign alloc_tag   = tail_q;
  // Free slots always sit between tail and head
  assign rob_free    = !busy_q[tail_q];
  assign head_retire = busy_q[head_q] && done_q[head_q];

  // Youngest busy slot older than the asking instruction wins
  function automatic operand_reply_t lookup(operand_query_t q);
    operand_reply_t   r;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] limit;
    // Value retiring this cycle is not in the register file yet
    r.hit   = retire_valid && (retire.rd == q.reg_idx);
    r.ready = 1'b1;
    r.value = retire.value;
    limit   = q.tag - head_q;
    for (int k = 0; k < `ROB_DEPTH; k++) begin
      idx = head_q + IDX_W'(k);
      if ((k < limit) && busy_q[idx] && (rd_q[idx] == q.reg_idx)) begin
        r.hit   = 1'b1;
        r.ready = done_q[idx];
        r.value = value_q[idx];
      end
    end
    return r;
  endfunction

  // Replies follow slot state as well as the queries
  always_comb begin
    reply_a = lookup(query_a);
    reply_b = lookup(query_b);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q       <= '0;
      done_q       <= '0;
      head_q       <= '0;
      tail_q       <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= head_retire;
      if (head_retire) begin
        busy_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      if (alloc) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (alu_res_valid)
        done_q[alu_res.tag] <= 1'b1;
      if (mul_res_valid)
        done_q[mul_res.tag] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (head_retire) begin
      retire.rd    <= rd_q[head_q];
      retire.value <= value_q[head_q];
    end
    if (alloc)
      rd_q[tail_q] <= alloc_rd;
    if (alu_res_valid)
      value_q[alu_res.tag] <= alu_res.value;
    if (mul_res_valid)
      value_q[mul_res.tag] <= mul_res.value;
  end

  // Results only land in reserved slots
  alu_res_to_busy: assert property (
    @(posedge clock) disable iff (reset) alu_res_valid |-> busy_q[alu_res.tag]
  );
  mul_res_to_busy: assert property (
    @(posedge clock) disable iff (reset) mul_res_valid |-> busy_q[mul_res.tag]
  );

endmodule

`default_nettype wire

// ==== hw/issue_ctrl.sv ====
`default_nettype none
`include "core_macros.svh"

module issue_ctrl (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           inst_valid,
  input  wire core_pkg::inst_t          inst,
  output logic                          full,
  output logic                          alloc,
  input  wire [`ROB_IDX_W-1:0]          alloc_tag,
  output logic                          push,
  output core_pkg::iq_entry_t           push_entry,
  input  wire                           head_valid,
  input  wire core_pkg::iq_entry_t      head,
  output logic                          pop,
  input  wire [$clog2(`IQ_DEPTH):0]     iq_count,
  input  wire                           rob_free,
  output core_pkg::operand_query_t      query_a,
  output core_pkg::operand_query_t      query_b,
  input  wire core_pkg::operand_reply_t reply_a,
  input  wire core_pkg::operand_reply_t reply_b,
  output logic [`REG_IDX_W-1:0]         rf_addr_a,
  output logic [`REG_IDX_W-1:0]         rf_addr_b,
  input  wire [`DATA_WIDTH-1:0]         rf_data_a,
  input  wire [`DATA_WIDTH-1:0]         rf_data_b,
  output logic                          alu_req_valid,
  output core_pkg::exec_req_t           alu_req,
  output logic                          mul_req_valid,
  output core_pkg::exec_req_t           mul_req
);
  import core_pkg::*;

  logic      accept;
  logic      a_wait;
  logic      b_wait;
  logic      can_issue;
  exec_req_t req;

  // No room in either the queue or the buffer
  assign full   = (iq_count == `IQ_DEPTH) || !rob_free;
  assign accept = inst_valid && !full;

  assign alloc      = accept;
  assign push       = accept;
  assign push_entry = '{inst: inst, tag: alloc_tag};

  // Operand lookup for the queue head
  assign query_a   = '{reg_idx: head.inst.ra, tag: head.tag};
  assign query_b   = '{reg_idx: head.inst.rb, tag: head.tag};
  assign rf_addr_a = head.inst.ra;
  assign rf_addr_b = head.inst.rb;

  // Producer still in flight
  assign a_wait    = reply_a.hit && !reply_a.ready;
  assign b_wait    = reply_b.hit && !reply_b.ready;
  assign can_issue = head_valid && !a_wait && !b_wait;

  always_comb begin
    req.opcode = head.inst.opcode;
    req.tag    = head.tag;
    req.a      = reply_a.hit ? reply_a.value : rf_data_a;
    req.b      = reply_b.hit ? reply_b.value : rf_data_b;
  end

  assign alu_req       = req;
  assign mul_req       = req;
  assign alu_req_valid = can_issue && (head.inst.opcode != op_mul);
  assign mul_req_valid = can_issue && (head.inst.opcode == op_mul);
  assign pop           = can_issue;

  // Source must hold off while the core reports full
  no_strobe_when_full: assert property (
    @(posedge clock) disable iff (reset) full |-> !inst_valid
  );

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`default_nettype none
`include "core_macros.svh"

module ooo_core (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    inst_valid,
  input  wire core_pkg::inst_t   inst,
  output logic                   full,
  output logic                   retire_valid,
  output core_pkg::retire_t      retire
);
  import core_pkg::*;

  logic                       alloc;
  logic [`ROB_IDX_W-1:0]      alloc_tag;
  logic                       rob_free;
  logic                       push;
  iq_entry_t                  push_entry;
  logic                       head_valid;
  iq_entry_t                  head;
  logic                       pop;
  logic [$clog2(`IQ_DEPTH):0] iq_count;
  operand_query_t             query_a;
  operand_query_t             query_b;
  operand_reply_t             reply_a;
  operand_reply_t             reply_b;
  logic [`REG_IDX_W-1:0]      rf_addr_a;
  logic [`REG_IDX_W-1:0]      rf_addr_b;
  logic [`DATA_WIDTH-1:0]     rf_data_a;
  logic [`DATA_WIDTH-1:0]     rf_data_b;
  logic                       alu_req_valid;
  exec_req_t                  alu_req;
  logic                       mul_req_valid;
  exec_req_t                  mul_req;
  logic                       alu_res_valid;
  exec_result_t               alu_res;
  logic                       mul_res_valid;
  exec_result_t               mul_res;

  issue_ctrl i_issue_ctrl (
    .clock         (clock),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .full          (full),
    .alloc         (alloc),
    .alloc_tag     (alloc_tag),
    .push          (push),
    .push_entry    (push_entry),
    .head_valid    (head_valid),
    .head          (head),
    .pop           (pop),
    .iq_count      (iq_count),
    .rob_free      (rob_free),
    .query_a       (query_a),
    .query_b       (query_b),
    .reply_a       (reply_a),
    .reply_b       (reply_b),
    .rf_addr_a     (rf_addr_a),
    .rf_addr_b     (rf_addr_b),
    .rf_data_a     (rf_data_a),
    .rf_data_b     (rf_data_b),
    .alu_req_valid (alu_req_valid),
    .alu_req       (alu_req),
    .mul_req_valid (mul_req_valid),
    .mul_req       (mul_req)
  );

  inst_queue i_inst_queue (
    .clock      (clock),
    .reset      (reset),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head),
    .count      (iq_count)
  );

  reorder_buffer i_reorder_buffer (
    .clock         (clock),
    .reset         (reset),
    .alloc         (alloc),
    .alloc_rd      (inst.rd),
    .alloc_tag     (alloc_tag),
    .rob_free      (rob_free),
    .query_a       (query_a),
    .query_b       (query_b),
    .reply_a       (reply_a),
    .reply_b       (reply_b),
    .alu_res_valid (alu_res_valid),
    .alu_res       (alu_res),
    .mul_res_valid (mul_res_valid),
    .mul_res       (mul_res),
    .retire_valid  (retire_valid),
    .retire        (retire)
  );

  alu_unit i_alu_unit (
    .clock     (clock),
    .reset     (reset),
    .req_valid (alu_req_valid),
    .req       (alu_req),
    .res_valid (alu_res_valid),
    .res       (alu_res)
  );

  mul_unit i_mul_unit (
    .clock     (clock),
    .reset     (reset),
    .req_valid (mul_req_valid),
    .req       (mul_req),
    .res_valid (mul_res_valid),
    .res       (mul_res)
  );

  reg_file i_reg_file (
    .clock     (clock),
    .reset     (reset),
    .rd_addr_a (rf_addr_a),
    .rd_addr_b (rf_addr_b),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr_valid  (retire_valid),
    .wr        (retire)
  );

endmodule

`default_nettype wire

// ==== verification/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Sequential reference of the core and the stimulus generator
logic [31:0]            rng_state = 32'd29;
logic [`DATA_WIDTH-1:0] model_regs [`NUM_REGS];
retire_t                expected_q [$];

function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic inst_t make_inst(opcode_t op, int rd, int ra, int rb);
  inst_t i;
  i.opcode = op;
  i.rd     = `REG_IDX_W'(rd);
  i.ra     = `REG_IDX_W'(ra);
  i.rb     = `REG_IDX_W'(rb);
  return i;
endfunction

// Only the six defined opcodes
function automatic inst_t random_inst();
  logic [31:0] r;
  r = next_random();
  return make_inst(opcode_t'(3'(r % 6)), int'(r[11:8]), int'(r[15:12]), int'(r[19:16]));
endfunction

function automatic void model_clear();
  for (int k = 0; k < `NUM_REGS; k++) begin
    model_regs[k] = '0;
  end
  expected_q.delete();
endfunction

function automatic void model_execute(inst_t i);
  logic [`DATA_WIDTH-1:0]   a;
  logic [`DATA_WIDTH-1:0]   b;
  logic [`DATA_WIDTH-1:0]   value;
  logic [2*`DATA_WIDTH-1:0] product;
  a = model_regs[i.ra];
  b = model_regs[i.rb];
  product = {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};
  case (i.opcode)
    op_add:  value = a + b;
    op_sub:  value = a - b;
    op_and:  value = a & b;
    op_or:   value = a | b;
    op_xor:  value = a ^ b;
    default: value = product[`DATA_WIDTH-1:0];
  endcase
  model_regs[i.rd] = value;
  expected_q.push_back('{rd: i.rd, value: value});
endfunction

`endif

// ==== verification/core_tb.sv ====
`default_nettype none
`include "core_macros.svh"

module core_tb;
  import core_pkg::*;

  `include "core_model.svh"

  localparam int WAIT_LIMIT = 500;

  logic    clock;
  logic    reset;
  logic    inst_valid;
  inst_t   inst;
  logic    full;
  logic    retire_valid;
  retire_t retire;

  int      error_count;
  int      issued_count;
  int      retired_count;
  logic    full_seen;
  retire_t expected_retire;
  logic [31:0] gap;

  ooo_core i_ooo_core (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .full         (full),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clock);
  endtask

  task automatic wait_not_full();
    int cycles;
    cycles = 0;
    while (full && cycles < WAIT_LIMIT) begin
      full_seen = 1'b1;
      @(negedge clock);
      cycles++;
    end
    if (full) begin
      error_count++;
      $display("ERROR at %0t: full stayed high for %0d cycles", $time, WAIT_LIMIT);
    end
  endtask

  // Called on a falling edge, holds the strobe for one cycle
  task automatic send_inst(input inst_t i);
    wait_not_full();
    if (!full) begin
      inst_valid = 1'b1;
      inst       = i;
      model_execute(i);
      issued_count++;
      @(negedge clock);
      inst_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (expected_q.size() != 0) begin
      error_count++;
      $display("ERROR at %0t: %0d results never retired", $time, expected_q.size());
    end
  endtask

  // Retire checker, outputs are settled at the falling edge
  always @(negedge clock) begin
    if (!reset && retire_valid) begin
      retired_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("ERROR at %0t: retire with no instruction outstanding", $time);
      end else begin
        expected_retire = expected_q.pop_front();
        check_value("retire.rd", retire.rd, expected_retire.rd);
        check_value("retire.value", retire.value, expected_retire.value);
      end
    end
  end

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    inst_valid    = 1'b0;
    inst          = '0;
    error_count   = 0;
    issued_count  = 0;
    retired_count = 0;
    full_seen     = 1'b0;
    model_clear();

    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // Quiet after reset
    check_value("retire_valid", retire_valid, 0);
    check_value("full", full, 0);
    idle(5);

    // One of each ALU opcode
    for (int k = 0; k < 5; k++) begin
      send_inst(make_inst(opcode_t'(3'(k)), k + 1, k + 2, k + 3));
      idle(1);
    end
    wait_drain();

    // Multiplies in flight together
    send_inst(make_inst(op_mul, 1, 2, 3));
    send_inst(make_inst(op_mul, 4, 5, 6));
    send_inst(make_inst(op_mul, 7, 8, 9));
    wait_drain();

    // Younger independent ALU ops finish first but retire after the multiply
    send_inst(make_inst(op_mul, 10, 11, 12));
    send_inst(make_inst(op_add, 13, 14, 15));
    send_inst(make_inst(op_sub, 2, 3, 5));
    send_inst(make_inst(op_xor, 6, 8, 9));
    wait_drain();

    // Dependent chain
    send_inst(make_inst(op_add, 1, 1, 2));
    send_inst(make_inst(op_mul, 2, 1, 1));
    send_inst(make_inst(op_sub, 3, 2, 1));
    send_inst(make_inst(op_or, 1, 3, 2));
    send_inst(make_inst(op_mul, 4, 1, 3));
    send_inst(make_inst(op_xor, 5, 4, 4));
    wait_drain();

    // Serial multiplies back up the queue until full rises
    repeat (16) send_inst(make_inst(op_mul, 7, 7, 7));

    repeat (200) begin
      send_inst(random_inst());
      gap = next_random();
      if (gap[2:0] == 3'd0)
        idle(int'(gap[5:4]));
    end
    wait_drain();
    idle(5);

    check_value("full_seen", full_seen, 1);
    check_value("retired_count", retired_count, issued_count);

    $display("errors: %0d  issued: %0d  retired: %0d", error_count, issued_count,
             retired_count);
    if (error_count == 0 && expected_q.size() == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
+incdir+verification
hw/core_pkg.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reg_file.sv
hw/inst_queue.sv
hw/reorder_buffer.sv
hw/issue_ctrl.sv
hw/ooo_core.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/alu_unit.sv
      - hw/mul_unit.sv
      - hw/reg_file.sv
      - hw/inst_queue.sv
      - hw/reorder_buffer.sv
      - hw/issue_ctrl.sv
      - hw/ooo_core.sv
  - target: simulation
    include_dirs:
      - hw
      - verification
    files:
      - verification/core_tb.sv
